/* Bender.yml */
package:
  name: rv32i_controller

sources:
  - verilog/ctrlPkg.sv
  - verilog/mainDecoder.sv
  - verilog/aluDecoder.sv
  - verilog/pipeCtrl.sv
  - verilog/controller.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/controllerTb.sv

/* tb/decodeRef.svh */
// Expected decode results worked out from the RV32I encoding tables
// Included inside the controller testbench module body
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic bit legalOpcode(input logic [6:0] opc);
  case (opc)
    7'h03, 7'h13, 7'h17, 7'h23, 7'h33: legalOpcode = 1'b1;   // load opImm auipc store op
    7'h37, 7'h63, 7'h67, 7'h6f, 7'h73: legalOpcode = 1'b1;   // lui branch jalr jal system
    default: legalOpcode = 1'b0;
  endcase
endfunction

function automatic logic [2:0] immFormat(input logic [31:0] w);
  case (w[6:0])
    7'h23:        immFormat = 3'd1;        // S
    7'h63:        immFormat = 3'd2;        // B
    7'h6f:        immFormat = 3'd3;        // J
    7'h17, 7'h37: immFormat = 3'd4;        // U
    default:      immFormat = 3'd0;        // I, also R and system
  endcase
endfunction

// 00 add, 01 funct3, 11 funct3 with sub/arith
function automatic logic [1:0] aluCtrlFor(input logic [31:0] w);
  logic alt;
  alt = (w[14:12] == 3'd2) || (w[14:12] == 3'd3) || (w[14:12] == 3'd5 && w[30]) ||
        (w[14:12] == 3'd0 && w[30] && w[6:0] == 7'h33);
  if (w[6:0] != 7'h13 && w[6:0] != 7'h33) aluCtrlFor = 2'b00;
  else aluCtrlFor = alt ? 2'b11 : 2'b01;
endfunction

function automatic bit csrAccess(input logic [31:0] w);
  csrAccess = (w[6:0] == 7'h73) && (w[14:12] != 3'd0);   // Privileged ops excluded
endfunction

function automatic bit writesRegister(input logic [31:0] w);
  writesRegister = legalOpcode(w[6:0]) && w[6:0] != 7'h23 && w[6:0] != 7'h63 &&
                   (w[6:0] != 7'h73 || csrAccess(w));
endfunction

function automatic logic [1:0] resultSource(input logic [31:0] w);
  resultSource = (w[6:0] == 7'h03) ? 2'd1 : (csrAccess(w) ? 2'd2 : 2'd0);
endfunction

function automatic bit redirectsFetch(input logic [31:0] w, input logic [1:0] flags);
  logic flag;
  flag = w[14] ? flags[0] : flags[1];      // lt or eq
  redirectsFetch = (w[6:0] == 7'h6f) || (w[6:0] == 7'h67) ||
                   (w[6:0] == 7'h63 && (flag ^ w[12]));
endfunction

// bltu and bgeu are the only unsigned compares
function automatic bit signedCompare(input logic [2:0] f3);
  signedCompare = (f3 != 3'd6) && (f3 != 3'd7);
endfunction

// {aluSrcA, aluSrcB, aluResultSrc, jump, memRead, csrRead} of a word in Execute
function automatic logic [5:0] execSelects(input logic [31:0] w);
  case (w[6:0])
    7'h03:        execSelects = 6'b010010;   // Address add, memory read
    7'h13, 7'h23: execSelects = 6'b010000;   // Immediate operand
    7'h17, 7'h63: execSelects = 6'b110000;   // PC plus immediate
    7'h37:        execSelects = 6'b011000;   // Immediate straight through
    7'h67:        execSelects = 6'b011100;   // Link value
    7'h6f:        execSelects = 6'b111100;
    7'h73:        execSelects = {5'b00000, csrAccess(w)};
    default:      execSelects = 6'b000000;   // R-type and illegal
  endcase
endfunction

// {memRw, privileged} of a word in Memory
function automatic logic [2:0] memFields(input logic [31:0] w);
  case (w[6:0])
    7'h03:   memFields = 3'b100;                      // Read
    7'h23:   memFields = 3'b010;                      // Write
    7'h73:   memFields = {2'b00, w[14:12] == 3'd0};   // ecall, ebreak, mret
    default: memFields = 3'b000;
  endcase
endfunction

`endif

/* tb/controllerTb.sv */
// Testbench for the RV32I pipeline controller
// Random and directed Decode words, checked by concurrent assertions
`timescale 1ns/1ps

module controllerTb;

  logic clk, arstN;
  logic [31:0] instrD;
  logic illegalIEUInstrD;
  logic stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW;
  logic [1:0] flagsE;                      // {eq, lt}
  ctrlPkg::immSrcT immSrcD;
  logic illegalInstrD, instrValidD, storeStallD, pcSrcE;
  ctrlPkg::aluCtrlT aluControlE;
  logic aluSrcAE, aluSrcBE, aluResultSrcE, memReadE, csrReadE;
  logic [2:0] funct3E, funct3M;
  logic jumpE, branchSignedE, instrValidE;
  ctrlPkg::memRwT memRwM;
  logic csrReadM, csrWriteM, privilegedM, regWriteM, instrValidM, regWriteW;
  ctrlPkg::resultSrcT resultSrcW;
  logic freeRun;                           // No stall, flush or squash
  int cycle = 0;
  int errCount = 0;
  int timeoutCount = 0;

  `include "decodeRef.svh"

  controller dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic logMismatch(input string msg);
    errCount++;
    $display("Error %0t: %s", $time, msg);
  endtask

  function automatic logic [31:0] randWord();
    logic [31:0] w;
    w = $urandom;
    if ($urandom_range(3) != 0) begin      // Mostly legal opcodes
      w[1:0] = 2'b11;
      for (int i = 0; i < 64 && !legalOpcode(w[6:0]); i++) begin
        w[6:2] = 5'($urandom);
      end
    end
    return w;
  endfunction

  task automatic driveWord(input logic [31:0] w);
    @(posedge clk);
    instrD <= w;
    flagsE <= 2'($urandom);
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////
  resetQuiet: assert property (@(posedge clk) (cycle >= 1 && (!arstN || $past(!arstN))) |->
    (!instrValidE && !instrValidM && !regWriteM && !regWriteW && !csrWriteM && !pcSrcE &&
     !storeStallD)) else logMismatch("state not cleared around reset");
  illegalMatch: assert property (@(posedge clk) disable iff (!arstN)
    illegalInstrD == !legalOpcode(instrD[6:0])) else logMismatch("illegalInstrD wrong");
  immMatch: assert property (@(posedge clk) disable iff (!arstN)
    (!illegalIEUInstrD && legalOpcode(instrD[6:0])) |-> immSrcD == immFormat(instrD))
    else logMismatch("immSrcD wrong");
  aluCtrlE: assert property (@(posedge clk) disable iff (!arstN)
    $past(freeRun) |-> aluControlE == aluCtrlFor($past(instrD)))
    else logMismatch("aluControlE wrong");
  execChk: assert property (@(posedge clk) disable iff (!arstN)
    $past(freeRun) |-> ({aluSrcAE, aluSrcBE, aluResultSrcE, jumpE, memReadE, csrReadE} ==
     execSelects($past(instrD)) && funct3E == $past(instrD[14:12])))
    else logMismatch("Execute fields wrong");
  regWriteMChk: assert property (@(posedge clk) disable iff (!arstN)
    ($past(freeRun) && $past(freeRun, 2)) |-> regWriteM == writesRegister($past(instrD, 2)))
    else logMismatch("regWriteM wrong");
  memFieldsChk: assert property (@(posedge clk) disable iff (!arstN)
    ($past(freeRun) && $past(freeRun, 2)) |->
    ({memRwM, privilegedM} == memFields($past(instrD, 2)) &&
     funct3M == $past(instrD[14:12], 2))) else logMismatch("Memory fields wrong");
  csrMChk: assert property (@(posedge clk) disable iff (!arstN)
    ($past(freeRun) && $past(freeRun, 2)) |-> (csrReadM == csrAccess($past(instrD, 2)) &&
     csrWriteM == (csrAccess($past(instrD, 2)) &&
                   !($past(instrD[13], 2) && $past(instrD[19:15], 2) == 5'd0))))
    else logMismatch("csrReadM or csrWriteM wrong");
  resultSrcWChk: assert property (@(posedge clk) disable iff (!arstN)
    ($past(freeRun) && $past(freeRun, 2) && $past(freeRun, 3)) |->
    resultSrcW == resultSource($past(instrD, 3))) else logMismatch("resultSrcW wrong");
  pcSrcChk: assert property (@(posedge clk) disable iff (!arstN)
    $past(freeRun) |-> pcSrcE == redirectsFetch($past(instrD), flagsE))
    else logMismatch("pcSrcE wrong");
  signedChk: assert property (@(posedge clk) disable iff (!arstN)
    $past(freeRun) |-> branchSignedE == signedCompare($past(instrD[14:12])))
    else logMismatch("branchSignedE wrong");
  storeStallChk: assert property (@(posedge clk) disable iff (!arstN)
    (freeRun && $past(freeRun)) |-> storeStallD == ($past(instrD[6:0]) == 7'h23 &&
     (instrD[6:0] == 7'h23 || instrD[6:0] == 7'h03))) else logMismatch("storeStallD wrong");
  stallHold: assert property (@(posedge clk) disable iff (!arstN)
    $past(stallE && !flushE) |-> (aluControlE == $past(aluControlE) &&
     funct3E == $past(funct3E))) else logMismatch("stalled Execute changed");
  flushClears: assert property (@(posedge clk) disable iff (!arstN)
    $past(flushE) |-> (!instrValidE && !pcSrcE)) else logMismatch("flushE left E active");
  ieuSquash: assert property (@(posedge clk) disable iff (!arstN)
    ($past(illegalIEUInstrD && !stallE && !flushE, 2) && $past(!stallM && !flushM)) |->
    !regWriteM) else logMismatch("squashed word wrote a register");

  task automatic runTests();
    @(posedge clk);
    freeRun <= 1'b1;
    repeat (400) driveWord(randWord());
    driveWord(32'h300020f3);               // csrrs x1, mstatus, x0
    driveWord(32'h3002a0f3);               // csrrs x1, mstatus, x5
    driveWord(32'h30007073);               // csrrci with zero uimm
    driveWord(32'h0020a023);               // sw then lw
    driveWord(32'h0000a183);
    driveWord(32'h402081b3);               // sub
    @(posedge clk);
    freeRun <= 1'b0;
    stallE <= 1'b1;                        // Hold Execute for 3 words
    instrD <= 32'h002081b3;
    repeat (3) driveWord(randWord());
    stallE <= 1'b0;
    driveWord(32'h008000ef);               // jal, then flush it in E
    @(posedge clk);
    flushE <= 1'b1;
    @(posedge clk);
    flushE <= 1'b0;
    instrD <= 32'h002081b3;
    illegalIEUInstrD <= 1'b1;
    @(posedge clk);
    illegalIEUInstrD <= 1'b0;
    repeat (4) driveWord(randWord());
  endtask

  task automatic finishRun();
    $display("Checks done: %0d errors, %0d timeouts", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    int unsigned seedDummy;
    int waitCount;
    seedDummy = $urandom(32'h8d03);
    arstN = 1'b0;
    instrD = 32'h0;
    illegalIEUInstrD = 1'b0;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    flagsE = 2'b00;
    freeRun = 1'b0;
    waitCount = 0;
    repeat (8) @(posedge clk);
    arstN <= 1'b1;
    while (!instrValidD && waitCount < 20) begin   // First Decode word
      @(posedge clk);
      waitCount++;
    end
    if (!instrValidD) begin
      timeoutCount++;
      $display("Timeout: instrValidD never rose after reset");
      finishRun();
    end else begin
      runTests();
      finishRun();
    end
  end

endmodule

/* verilog/aluDecoder.sv */
// ALU operation decoder working beside the main decoder in Decode
// Picks plain add, the funct3 operation, or its subtract/arithmetic variant
`timescale 1ns/1ps

module aluDecoder (
  input  logic [ctrlPkg::instrW-1:0] instrD,      // Decode stage instruction
  input  logic                       aluOpD,      // From main decoder
  output ctrlPkg::aluCtrlT           aluControlD
);

  logic [ctrlPkg::opcodeW-1:0] opcode;
  logic [ctrlPkg::funct3W-1:0] funct3;
  logic [ctrlPkg::funct7W-1:0] funct7;
  logic                        altBit;            // Sub or sra selector
  logic                        subD, sraD, sltD, sltuD;
  logic                        subArithD;

  assign opcode = instrD[ctrlPkg::opcodeLsb +: ctrlPkg::opcodeW];
  assign funct3 = instrD[ctrlPkg::funct3Lsb +: ctrlPkg::funct3W];
  assign funct7 = instrD[ctrlPkg::funct7Lsb +: ctrlPkg::funct7W];
  assign altBit = funct7[ctrlPkg::funct7AltBit - ctrlPkg::funct7Lsb];

  // Opcode bit 5 tells R-type sub apart from addi
  assign subD  = (funct3 == 3'b000) & altBit & opcode[5];
  assign sraD  = (funct3 == 3'b101) & altBit;
  assign sltD  = (funct3 == 3'b010);       // Compare needs the subtractor
  assign sltuD = (funct3 == 3'b011);

  assign subArithD = subD | sraD | sltD | sltuD;

  always_comb begin
    if (!aluOpD)
      aluControlD = ctrlPkg::aluAdd;       // Loads, stores, jumps, auipc
    else if (subArithD)
      aluControlD = ctrlPkg::aluFunctAlt;
    else
      aluControlD = ctrlPkg::aluFunct;
  end

  // Variant only reachable through a real ALU op
  noAltOnAdd: assert final (aluOpD || aluControlD != ctrlPkg::aluFunctAlt);

endmodule

/* verilog/controller.sv */
// Top of the RV32I pipeline controller
// Two Decode stage decoders feed the stage-by-stage control registers
`timescale 1ns/1ps

module controller (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [ctrlPkg::instrW-1:0]    instrD,
  input  logic                          illegalIEUInstrD,
  input  logic                          stallD, flushD,
  input  logic                          stallE, flushE,
  input  logic                          stallM, flushM,
  input  logic                          stallW, flushW,
  input  logic [1:0]                    flagsE,           // {eq, lt}
  output ctrlPkg::immSrcT               immSrcD,
  output logic                          illegalInstrD,
  output logic                          instrValidD, storeStallD,
  output logic                          pcSrcE,
  output ctrlPkg::aluCtrlT              aluControlE,
  output logic                          aluSrcAE, aluSrcBE,
  output logic                          aluResultSrcE,
  output logic                          memReadE, csrReadE,
  output logic [ctrlPkg::funct3W-1:0]   funct3E,
  output logic                          jumpE, branchSignedE, instrValidE,
  output ctrlPkg::memRwT                memRwM,
  output logic                          csrReadM, csrWriteM, privilegedM,
  output logic [ctrlPkg::funct3W-1:0]   funct3M,
  output logic                          regWriteM, instrValidM,
  output logic                          regWriteW,
  output ctrlPkg::resultSrcT            resultSrcW
);

  // Decode stage fields between decoders and pipeline
  logic               regWriteD, aluSrcAD, aluSrcBD, branchD, jumpD;
  logic               aluOpD, aluResultSrcD, csrReadD, privilegedD;
  ctrlPkg::memRwT     memRwD;
  ctrlPkg::resultSrcT resultSrcD;
  ctrlPkg::aluCtrlT   aluControlD;

  mainDecoder mainDec_i (
    .instrD, .illegalIEUInstrD, .regWriteD, .immSrcD, .aluSrcAD, .aluSrcBD,
    .memRwD, .resultSrcD, .branchD, .jumpD, .aluOpD, .aluResultSrcD,
    .csrReadD, .privilegedD, .illegalD(illegalInstrD)
  );

  aluDecoder aluDec_i (
    .instrD, .aluOpD, .aluControlD
  );

  pipeCtrl pipe_i (
    .clk, .arstN, .stallD, .flushD, .stallE, .flushE, .stallM, .flushM,
    .stallW, .flushW, .instrD, .regWriteD, .aluSrcAD, .aluSrcBD, .memRwD,
    .resultSrcD, .branchD, .jumpD, .aluOpD, .aluResultSrcD, .csrReadD,
    .privilegedD, .aluControlD, .flagsE, .instrValidD, .storeStallD,
    .pcSrcE, .aluControlE, .aluSrcAE, .aluSrcBE, .aluResultSrcE, .memReadE,
    .csrReadE, .funct3E, .jumpE, .branchSignedE, .instrValidE, .memRwM,
    .csrReadM, .csrWriteM, .privilegedM, .funct3M, .regWriteM, .instrValidM,
    .regWriteW, .resultSrcW
  );

endmodule

/* verilog/ctrlPkg.sv */
// Control types and instruction field positions shared by the RV32I pipeline controller
// Decoders and the pipeline control block refer to these by scoped name
package ctrlPkg;

  //////////////////////////////
  // Instruction field positions
  //////////////////////////////
  localparam int instrW       = 32;        // Instruction word
  localparam int opcodeLsb    = 0;
  localparam int opcodeW      = 7;
  localparam int funct3Lsb    = 12;
  localparam int funct3W      = 3;
  localparam int funct7Lsb    = 25;
  localparam int funct7W      = 7;
  localparam int rs1Lsb       = 15;
  localparam int rs1W         = 5;
  localparam int funct7AltBit = 30;        // Sub and sra select bit

  localparam logic [funct3W-1:0] funct3Priv = 3'b000; // ecall, ebreak, mret, wfi

  //////////////////////////////
  // Major opcodes kept for RV32I
  //////////////////////////////
  typedef enum logic [opcodeW-1:0] {
    load   = 7'b0000011,
    opImm  = 7'b0010011,
    auipc  = 7'b0010111,
    store  = 7'b0100011,
    op     = 7'b0110011,
    lui    = 7'b0110111,
    branch = 7'b1100011,
    jalr   = 7'b1100111,
    jal    = 7'b1101111,
    system = 7'b1110011                    // CSR access and privileged
  } opcodeT;

  // Immediate formats for the extend unit
  typedef enum logic [2:0] {
    immI = 3'b000,
    immS = 3'b001,
    immB = 3'b010,
    immJ = 3'b011,
    immU = 3'b100
  } immSrcT;

  // Writeback result source
  typedef enum logic [1:0] {
    srcAlu = 2'b00,
    srcMem = 2'b01,
    srcCsr = 2'b10
  } resultSrcT;

  // ALU control as {subArith, aluOp}
  typedef enum logic [1:0] {
    aluAdd      = 2'b00,                   // Address gen or plain add
    aluFunct    = 2'b01,                   // Operation from funct3
    aluFunctAlt = 2'b11                    // funct3 with sub/arith variant
  } aluCtrlT;

  // Memory access pair, bit 1 read and bit 0 write
  typedef logic [1:0] memRwT;

endpackage

/* verilog/mainDecoder.sv */
// Main opcode decoder for the Decode stage instruction
// Turns the opcode into control fields and flags opcodes outside RV32I
`timescale 1ns/1ps

module mainDecoder (
  input  logic [ctrlPkg::instrW-1:0] instrD,           // Decode stage instruction
  input  logic                       illegalIEUInstrD, // Squash all fields
  output logic                       regWriteD,
  output ctrlPkg::immSrcT            immSrcD,
  output logic                       aluSrcAD,         // 1 selects PC
  output logic                       aluSrcBD,         // 1 selects immediate
  output ctrlPkg::memRwT             memRwD,
  output ctrlPkg::resultSrcT         resultSrcD,
  output logic                       branchD,
  output logic                       jumpD,
  output logic                       aluOpD,           // 0 means address add
  output logic                       aluResultSrcD,    // Pass immediate or PC+4
  output logic                       csrReadD,
  output logic                       privilegedD,
  output logic                       illegalD          // Opcode not implemented
);

  logic [ctrlPkg::opcodeW-1:0] opcode;
  logic [ctrlPkg::funct3W-1:0] funct3;

  // Unsquashed decode results
  logic                 regWriteR, aluSrcAR, aluSrcBR, branchR, jumpR;
  logic                 aluOpR, aluResultSrcR, csrReadR, privilegedR;
  ctrlPkg::immSrcT      immSrcR;
  ctrlPkg::memRwT       memRwR;
  ctrlPkg::resultSrcT   resultSrcR;

  assign opcode = instrD[ctrlPkg::opcodeLsb +: ctrlPkg::opcodeW];
  assign funct3 = instrD[ctrlPkg::funct3Lsb +: ctrlPkg::funct3W];

  //////////////////////////////
  // Opcode table
  //////////////////////////////
  always_comb begin
    regWriteR     = 1'b0;                  // Everything inactive by default
    immSrcR       = ctrlPkg::immI;
    aluSrcAR      = 1'b0;
    aluSrcBR      = 1'b0;
    memRwR        = 2'b00;
    resultSrcR    = ctrlPkg::srcAlu;
    branchR       = 1'b0;
    jumpR         = 1'b0;
    aluOpR        = 1'b0;
    aluResultSrcR = 1'b0;
    csrReadR      = 1'b0;
    privilegedR   = 1'b0;
    illegalD      = 1'b0;
    case (opcode)
      ctrlPkg::load: begin
        regWriteR  = 1'b1;
        aluSrcBR   = 1'b1;
        memRwR     = 2'b10;
        resultSrcR = ctrlPkg::srcMem;
      end
      ctrlPkg::opImm: begin
        regWriteR = 1'b1;
        aluSrcBR  = 1'b1;
        aluOpR    = 1'b1;
      end
      ctrlPkg::auipc: begin
        regWriteR = 1'b1;
        immSrcR   = ctrlPkg::immU;
        aluSrcAR  = 1'b1;                  // PC + upper immediate
        aluSrcBR  = 1'b1;
      end
      ctrlPkg::store: begin
        immSrcR  = ctrlPkg::immS;
        aluSrcBR = 1'b1;
        memRwR   = 2'b01;
      end
      ctrlPkg::op: begin
        regWriteR = 1'b1;
        aluOpR    = 1'b1;
      end
      ctrlPkg::lui: begin
        regWriteR     = 1'b1;
        immSrcR       = ctrlPkg::immU;
        aluSrcBR      = 1'b1;
        aluResultSrcR = 1'b1;              // Immediate straight through
      end
      ctrlPkg::branch: begin
        immSrcR  = ctrlPkg::immB;
        aluSrcAR = 1'b1;                   // Target is PC + offset
        aluSrcBR = 1'b1;
        branchR  = 1'b1;
      end
      ctrlPkg::jalr: begin
        regWriteR     = 1'b1;
        aluSrcBR      = 1'b1;
        jumpR         = 1'b1;
        aluResultSrcR = 1'b1;              // Link value
      end
      ctrlPkg::jal: begin
        regWriteR     = 1'b1;
        immSrcR       = ctrlPkg::immJ;
        aluSrcAR      = 1'b1;
        aluSrcBR      = 1'b1;
        jumpR         = 1'b1;
        aluResultSrcR = 1'b1;
      end
      ctrlPkg::system: begin
        if (funct3 == ctrlPkg::funct3Priv) begin
          privilegedR = 1'b1;              // Decoded further by privileged unit
        end else begin
          regWriteR  = 1'b1;
          resultSrcR = ctrlPkg::srcCsr;
          csrReadR   = 1'b1;
        end
      end
      default: illegalD = 1'b1;
    endcase
  end

  // IEU fault squashes the fields but leaves illegalD alone
  assign regWriteD     = illegalIEUInstrD ? 1'b0 : regWriteR;
  assign immSrcD       = illegalIEUInstrD ? ctrlPkg::immI : immSrcR;
  assign aluSrcAD      = illegalIEUInstrD ? 1'b0 : aluSrcAR;
  assign aluSrcBD      = illegalIEUInstrD ? 1'b0 : aluSrcBR;
  assign memRwD        = illegalIEUInstrD ? 2'b00 : memRwR;
  assign resultSrcD    = illegalIEUInstrD ? ctrlPkg::srcAlu : resultSrcR;
  assign branchD       = illegalIEUInstrD ? 1'b0 : branchR;
  assign jumpD         = illegalIEUInstrD ? 1'b0 : jumpR;
  assign aluOpD        = illegalIEUInstrD ? 1'b0 : aluOpR;
  assign aluResultSrcD = illegalIEUInstrD ? 1'b0 : aluResultSrcR;
  assign csrReadD      = illegalIEUInstrD ? 1'b0 : csrReadR;
  assign privilegedD   = illegalIEUInstrD ? 1'b0 : privilegedR;

  // Unknown opcode must never write state, whatever the squash input does
  illegalQuiet: assert final (!illegalD || (!regWriteD && memRwD == 2'b00 && !csrReadD));

endmodule

/* verilog/pipeCtrl.sv */
// Pipeline control registers for Execute, Memory and Writeback
// Also resolves branches, decides CSR writes and raises the store stall
`timescale 1ns/1ps

module pipeCtrl (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          stallD, flushD,
  input  logic                          stallE, flushE,
  input  logic                          stallM, flushM,
  input  logic                          stallW, flushW,
  // Decode fields
  input  logic [ctrlPkg::instrW-1:0]    instrD,
  input  logic                          regWriteD,
  input  logic                          aluSrcAD, aluSrcBD,
  input  ctrlPkg::memRwT                memRwD,
  input  ctrlPkg::resultSrcT            resultSrcD,
  input  logic                          branchD, jumpD,
  input  logic                          aluOpD,
  input  logic                          aluResultSrcD,
  input  logic                          csrReadD, privilegedD,
  input  ctrlPkg::aluCtrlT              aluControlD,
  input  logic [1:0]                    flagsE,           // {eq, lt}
  output logic                          instrValidD,
  output logic                          storeStallD,
  // Execute
  output logic                          pcSrcE,           // Redirect fetch
  output ctrlPkg::aluCtrlT              aluControlE,
  output logic                          aluSrcAE, aluSrcBE,
  output logic                          aluResultSrcE,
  output logic                          memReadE, csrReadE,
  output logic [ctrlPkg::funct3W-1:0]   funct3E,
  output logic                          jumpE,
  output logic                          branchSignedE,
  output logic                          instrValidE,
  // Memory
  output ctrlPkg::memRwT                memRwM,
  output logic                          csrReadM, csrWriteM, privilegedM,
  output logic [ctrlPkg::funct3W-1:0]   funct3M,
  output logic                          regWriteM,
  output logic                          instrValidM,
  // Writeback
  output logic                          regWriteW,
  output ctrlPkg::resultSrcT            resultSrcW
);

  logic [ctrlPkg::funct3W-1:0] funct3D;
  logic [ctrlPkg::rs1W-1:0]    rs1D;
  logic                        csrWriteD;
  logic                        regWriteE, branchE, csrWriteE, privilegedE;
  ctrlPkg::memRwT              memRwE;
  ctrlPkg::resultSrcT          resultSrcE, resultSrcM;
  logic                        eqE, ltE, branchFlagE, branchTakenE;

  assign funct3D = instrD[ctrlPkg::funct3Lsb +: ctrlPkg::funct3W];
  assign rs1D    = instrD[ctrlPkg::rs1Lsb +: ctrlPkg::rs1W];

  // csrrs/csrrc with x0 (or zero uimm) only read
  assign csrWriteD = csrReadD & ~(funct3D[1] & (rs1D == '0));

  //////////////////////////////
  // Decode
  //////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)       instrValidD <= 1'b0;
    else if (flushD)  instrValidD <= 1'b0;
    else if (!stallD) instrValidD <= 1'b1;   // Fetch delivered a word
  end

  // Back-to-back memory access after a store
  assign storeStallD = memRwE[0] & (memRwD[1] | memRwD[0]);

  //////////////////////////////
  // Execute
  //////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN || flushE) begin
      {regWriteE, jumpE, branchE, aluSrcAE, aluSrcBE} <= '0;
      {aluResultSrcE, csrReadE, csrWriteE, privilegedE, instrValidE} <= '0;
      memRwE      <= 2'b00;
      resultSrcE  <= ctrlPkg::srcAlu;
      aluControlE <= ctrlPkg::aluAdd;
      funct3E     <= '0;
    end else if (!stallE) begin
      regWriteE     <= regWriteD;
      jumpE         <= jumpD;
      branchE       <= branchD;
      aluSrcAE      <= aluSrcAD;
      aluSrcBE      <= aluSrcBD;
      aluResultSrcE <= aluResultSrcD;
      csrReadE      <= csrReadD;
      csrWriteE     <= csrWriteD;
      privilegedE   <= privilegedD;
      instrValidE   <= instrValidD;
      memRwE        <= memRwD;
      resultSrcE    <= resultSrcD;
      aluControlE   <= aluControlD;
      funct3E       <= funct3D;
    end
  end

  // Comparator supplies eq and lt only; signedness chosen by funct3
  assign {eqE, ltE}    = flagsE;
  assign branchFlagE   = funct3E[2] ? ltE : eqE;       // blt/bge family vs beq/bne
  assign branchTakenE  = branchFlagE ^ funct3E[0];     // Odd funct3 inverts
  assign pcSrcE        = jumpE | (branchE & branchTakenE);
  assign branchSignedE = ~(funct3E[2:1] == 2'b11);     // bltu, bgeu unsigned
  assign memReadE      = memRwE[1];

  //////////////////////////////
  // Memory
  //////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN || flushM) begin
      {regWriteM, csrReadM, csrWriteM, privilegedM, instrValidM} <= '0;
      memRwM     <= 2'b00;
      resultSrcM <= ctrlPkg::srcAlu;
      funct3M    <= '0;
    end else if (!stallM) begin
      regWriteM   <= regWriteE;
      csrReadM    <= csrReadE;
      csrWriteM   <= csrWriteE;
      privilegedM <= privilegedE;
      instrValidM <= instrValidE;
      memRwM      <= memRwE;
      resultSrcM  <= resultSrcE;
      funct3M     <= funct3E;                // Load size and sign
    end
  end

  //////////////////////////////
  // Writeback
  //////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN || flushW) begin
      regWriteW  <= 1'b0;
      resultSrcW <= ctrlPkg::srcAlu;
    end else if (!stallW) begin
      regWriteW  <= regWriteM;
      resultSrcW <= resultSrcM;
    end
  end

  // Flushed Execute slot can neither count as valid nor redirect fetch
  flushEmptiesE: assert property (@(posedge clk) disable iff (!arstN)
    flushE |=> (!instrValidE && !pcSrcE));

endmodule

/* vlog.f */
+incdir+tb
verilog/ctrlPkg.sv
verilog/mainDecoder.sv
verilog/aluDecoder.sv
verilog/pipeCtrl.sv
verilog/controller.sv
tb/controllerTb.sv
